// ==== all.f ====
hdl/video_pkg.sv
hdl/ppu_regs_pkg.sv
hdl/video_timing.sv
hdl/ppu_mmr.sv
hdl/layer_mixer.sv
hdl/palette.sv
hdl/cps_video.sv
tests/cps_video_asserts.sv
tests/cps_video_tb.sv

// ==== Makefile ====
SRCS := $(wildcard hdl/*.sv) $(wildcard tests/*.sv)

.PHONY: run clean

obj_dir/Vcps_video_tb: all.f $(SRCS)
	verilator --binary --timing --assert -f all.f --top-module cps_video_tb -o Vcps_video_tb

run: obj_dir/Vcps_video_tb
	./obj_dir/Vcps_video_tb > sim.log 2>&1; cat sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tests/cps_video_tb.sv ====
`timescale 1ns/1ps

module cps_video_tb
    import video_pkg::*;
    import ppu_regs_pkg::*;
();

    localparam int NUM_ROWS    = 7;
    localparam int FRAME_STEPS = H_TOTAL * V_TOTAL;
    localparam int WAIT_LIMIT  = 4 * FRAME_STEPS + 100;

    logic       clk;
    logic       rst;
    logic       pxl_cen;
    logic       ppu_cs;
    logic       pal_cs;
    logic       cpu_we;
    pal_idx_t   addr;
    logic [1:0] dsn;
    cpu_word_t  cpu_dout;
    layer_pxl_t obj_pxl;
    layer_pxl_t scr1_pxl;
    layer_pxl_t scr2_pxl;
    layer_pxl_t scr3_pxl;
    cpu_word_t  mmr_dout;
    logic       raster;
    hcount_t    hdump;
    vcount_t    vdump;
    logic       HS;
    logic       VS;
    logic       HB;
    logic       VB;
    logic       LHBL_dly;
    logic       LVBL_dly;
    channel_t   red;
    channel_t   green;
    channel_t   blue;

    int         errors;
    pal_entry_t pal_copy [PAL_ENTRIES];
    logic       raster_en;
    vcount_t    raster_line;

    // Mixer table columns
    cpu_word_t  row_ctrl [NUM_ROWS];
    layer_pxl_t row_obj  [NUM_ROWS];
    layer_pxl_t row_scr1 [NUM_ROWS];
    layer_pxl_t row_scr2 [NUM_ROWS];
    layer_pxl_t row_scr3 [NUM_ROWS];
    pal_idx_t   row_exp  [NUM_ROWS];

    cps_video dut_i (.*);

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    // Pixel enable on every second cycle
    always @(posedge clk) begin
        #1 pxl_cen <= ~pxl_cen;
    end

    task automatic check_val(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("FAILED t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
        end
    endtask

    task automatic write_bus(input logic to_pal, input pal_idx_t a, input cpu_word_t d,
                             input logic [1:0] lanes);
        @(posedge clk);
        #1;
        ppu_cs   = ~to_pal;
        pal_cs   = to_pal;
        cpu_we   = 1'b1;
        addr     = a;
        dsn      = lanes;
        cpu_dout = d;
        @(posedge clk);
        #1;
        ppu_cs = 1'b0;
        pal_cs = 1'b0;
        cpu_we = 1'b0;
        dsn    = 2'b11;
    endtask

    task automatic read_reg(input pal_idx_t a, output cpu_word_t d);
        @(posedge clk);
        #1;
        ppu_cs = 1'b1;
        cpu_we = 1'b0;
        addr   = a;
        #1;
        d      = mmr_dout;
        ppu_cs = 1'b0;
    endtask

    task automatic expect_reg(input pal_idx_t a, input cpu_word_t exp);
        cpu_word_t d;
        read_reg(a, d);
        check_val($sformatf("mmr_dout[%0d]", a), int'(d), int'(exp));
    endtask

    task automatic write_pal(input pal_idx_t idx, input pal_entry_t val);
        write_bus(1'b1, idx, val, 2'b00);
        pal_copy[idx] = val;
    endtask

    // Wait for a pixel position on a visible line
    task automatic wait_pos(input int h);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!(int'(hdump) == h && int'(vdump) > V_VIS_START && int'(vdump) < V_VIS_END)
               && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= WAIT_LIMIT) begin
            errors++;
            $display("Timeout waiting for hdump %0d on a visible line", h);
        end
    endtask

    // One full frame from line 0, pixel 0, checking timing, blanking and raster
    task automatic scan_frame();
        int      cycles;
        int      steps;
        int      lines;
        int      raster_hi;
        int      dly_h;
        int      dly_v;
        hcount_t prev_h;
        logic    done;
        logic    exp_hb;
        logic    exp_vb;
        logic    exp_hs;
        logic    exp_vs;
        logic    exp_lhbl;
        logic    exp_lvbl;
        logic    exp_raster;
        cycles = 0;
        @(negedge clk);
        while (!(hdump == '0 && vdump == '0) && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= WAIT_LIMIT) begin
            errors++;
            $display("Timeout waiting for the start of a frame");
            return;
        end
        steps     = 0;
        lines     = 0;
        raster_hi = 0;
        done      = 1'b0;
        cycles    = 0;
        prev_h    = hdump;
        while (!done && cycles < WAIT_LIMIT) begin
            if (pxl_cen) begin
                steps++;
            end
            exp_hb = int'(hdump) < H_VIS_START || int'(hdump) >= H_VIS_END;
            exp_vb = int'(vdump) < V_VIS_START || int'(vdump) >= V_VIS_END;
            check_val("HB", int'(HB), int'(exp_hb));
            check_val("VB", int'(VB), int'(exp_vb));
            exp_hs = int'(hdump) >= H_SYNC_START && int'(hdump) < H_SYNC_END;
            exp_vs = int'(vdump) >= V_SYNC_START && int'(vdump) < V_SYNC_END;
            check_val("HS", int'(HS), int'(exp_hs));
            check_val("VS", int'(VS), int'(exp_vs));
            // Delayed blanking belongs to the pixel PIPE_DEPTH steps back
            dly_h = int'(hdump) - PIPE_DEPTH;
            dly_v = int'(vdump);
            if (dly_h < 0) begin
                dly_h = dly_h + H_TOTAL;
                dly_v = (dly_v + V_TOTAL - 1) % V_TOTAL;
            end
            exp_lhbl = dly_h >= H_VIS_START && dly_h < H_VIS_END;
            exp_lvbl = dly_v >= V_VIS_START && dly_v < V_VIS_END;
            check_val("LHBL_dly", int'(LHBL_dly), int'(exp_lhbl));
            check_val("LVBL_dly", int'(LVBL_dly), int'(exp_lvbl));
            if ((!LHBL_dly || !LVBL_dly) && {red, green, blue} != '0) begin
                check_val("rgb_blank", int'({red, green, blue}), 0);
            end
            exp_raster = raster_en && vdump == raster_line;
            if (raster != exp_raster && !(raster_en && hdump == '0)) begin
                check_val("raster", int'(raster), int'(exp_raster));
            end
            if (raster) begin
                raster_hi++;
            end
            @(negedge clk);
            cycles++;
            if (int'(prev_h) == H_TOTAL - 1 && hdump == '0) begin
                lines++;
                done = vdump == '0;
            end
            prev_h = hdump;
        end
        if (!done) begin
            errors++;
            $display("Timeout waiting for the end of a frame");
        end
        check_val("frame_steps", steps, FRAME_STEPS);
        check_val("frame_lines", lines, V_TOTAL);
        if (raster_en && raster_hi == 0) begin
            errors++;
            $display("Raster never went high on the enabled line");
        end
    endtask

    task automatic add_row(input int r, input cpu_word_t ctrl, input layer_pxl_t o,
                           input layer_pxl_t s1, input layer_pxl_t s2,
                           input layer_pxl_t s3, input pal_idx_t exp);
        row_ctrl[r] = ctrl;
        row_obj[r]  = o;
        row_scr1[r] = s1;
        row_scr2[r] = s2;
        row_scr3[r] = s3;
        row_exp[r]  = exp;
    endtask

    initial begin
        cpu_word_t  got;
        pal_entry_t e;
        void'($urandom(90984));
        errors      = 0;
        rst         = 1'b1;
        pxl_cen     = 1'b0;
        ppu_cs      = 1'b0;
        pal_cs      = 1'b0;
        cpu_we      = 1'b0;
        addr        = '0;
        dsn         = 2'b11;
        cpu_dout    = '0;
        obj_pxl     = 8'hff;
        scr1_pxl    = 8'hff;
        scr2_pxl    = 8'hff;
        scr3_pxl    = 8'hff;
        raster_en   = 1'b0;
        raster_line = '0;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        // Register readback and byte lanes
        expect_reg(pal_idx_t'(REG_LAYER_CTRL), 16'h0000);
        expect_reg(pal_idx_t'(REG_RASTER), 16'h0000);
        expect_reg(pal_idx_t'(REG_BACKDROP), 16'h0000);
        write_bus(1'b0, pal_idx_t'(REG_LAYER_CTRL), 16'h1234, 2'b00);
        expect_reg(pal_idx_t'(REG_LAYER_CTRL), 16'h1234);
        write_bus(1'b0, pal_idx_t'(REG_LAYER_CTRL), 16'hab00, 2'b01);
        expect_reg(pal_idx_t'(REG_LAYER_CTRL), 16'hab34);
        write_bus(1'b0, pal_idx_t'(REG_LAYER_CTRL), 16'h00cd, 2'b10);
        expect_reg(pal_idx_t'(REG_LAYER_CTRL), 16'habcd);
        write_bus(1'b0, pal_idx_t'(REG_BACKDROP), 16'h0155, 2'b00);
        expect_reg(pal_idx_t'(REG_BACKDROP), 16'h0155);
        expect_reg(10'd3, UNMAPPED_READ);
        expect_reg(10'd31, UNMAPPED_READ);

        // Fields {f3,f2,f1,f0} in the low byte, enables in bits 11:8
        add_row(0, 16'h0fe4, 8'h12, 8'h34, 8'h56, 8'h78, 10'h378);
        add_row(1, 16'h0fe4, 8'h12, 8'h34, 8'h56, 8'h7f, 10'h256);
        add_row(2, 16'h0f1b, 8'h12, 8'h34, 8'h56, 8'h78, 10'h012);
        add_row(3, 16'h0e1b, 8'h12, 8'h34, 8'h56, 8'h78, 10'h134);
        add_row(4, 16'h0fe4, 8'h1f, 8'h3f, 8'h5f, 8'h7f, 10'h155);
        add_row(5, 16'h00e4, 8'h12, 8'h34, 8'h56, 8'h78, 10'h155);
        add_row(6, 16'h0f42, 8'h12, 8'h3f, 8'h56, 8'h78, 10'h012);

        for (int r = 0; r < NUM_ROWS; r++) begin
            write_pal(row_exp[r], pal_entry_t'($urandom()) | 16'h0111);
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            write_bus(1'b0, pal_idx_t'(REG_LAYER_CTRL), row_ctrl[r], 2'b00);
            @(posedge clk);
            #1;
            obj_pxl  = row_obj[r];
            scr1_pxl = row_scr1[r];
            scr2_pxl = row_scr2[r];
            scr3_pxl = row_scr3[r];
            wait_pos(0);
            wait_pos(200);
            e = pal_copy[row_exp[r]];
            check_val($sformatf("red[row %0d]", r), int'(red), int'({e[11:8], e[11:8]}));
            check_val($sformatf("green[row %0d]", r), int'(green), int'({e[7:4], e[7:4]}));
            check_val($sformatf("blue[row %0d]", r), int'(blue), int'({e[3:0], e[3:0]}));
        end

        // Timing and blanking with a non-black picture, raster off
        write_bus(1'b0, pal_idx_t'(REG_LAYER_CTRL), row_ctrl[0], 2'b00);
        write_bus(1'b0, pal_idx_t'(REG_RASTER), 16'h0064, 2'b00);
        raster_line = 9'd100;
        scan_frame();

        // Raster on line 100
        write_bus(1'b0, pal_idx_t'(REG_RASTER), 16'h8064, 2'b00);
        raster_en = 1'b1;
        read_reg(pal_idx_t'(REG_RASTER), got);
        check_val("raster_reg", int'(got), 16'h8064);
        scan_frame();

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tests/cps_video_asserts.sv ====
`timescale 1ns/1ps

module cps_video_asserts
    import video_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     pxl_cen,
    input hcount_t  hdump,
    input logic     HB,
    input logic     HS,
    input logic     LHBL_dly,
    input logic     LVBL_dly,
    input channel_t red,
    input channel_t green,
    input channel_t blue
);

    // Horizontal counter steps by one per pixel and wraps at the line length
    hdump_step: assert property (@(posedge clk) disable iff (rst)
        pxl_cen |=> int'(hdump) == (int'($past(hdump)) + 1) % H_TOTAL)
        else $error("hdump did not step from %0d", $past(hdump));

    // Colour is black while the delayed blanking is active
    blank_black: assert property (@(posedge clk) disable iff (rst)
        (!LHBL_dly || !LVBL_dly) |-> (red == '0 && green == '0 && blue == '0))
        else $error("RGB not black during blanking");

    // Horizontal sync sits inside horizontal blanking
    hs_in_hb: assert property (@(posedge clk) disable iff (rst)
        HS |-> HB)
        else $error("HS active outside HB");

endmodule

bind cps_video cps_video_asserts asserts_i (.*);

// ==== hdl/cps_video.sv ====
`timescale 1ns/1ps

module cps_video
    import video_pkg::*;
    import ppu_regs_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       pxl_cen,
    input  logic       ppu_cs,
    input  logic       pal_cs,
    input  logic       cpu_we,
    input  pal_idx_t   addr,
    input  logic [1:0] dsn,
    input  cpu_word_t  cpu_dout,
    input  layer_pxl_t obj_pxl,
    input  layer_pxl_t scr1_pxl,
    input  layer_pxl_t scr2_pxl,
    input  layer_pxl_t scr3_pxl,
    output cpu_word_t  mmr_dout,
    output logic       raster,
    output hcount_t    hdump,
    output vcount_t    vdump,
    output logic       HS,
    output logic       VS,
    output logic       HB,
    output logic       VB,
    output logic       LHBL_dly,
    output logic       LVBL_dly,
    output channel_t   red,
    output channel_t   green,
    output channel_t   blue
);

    cpu_word_t layer_ctrl;
    pal_idx_t  backdrop;
    pal_idx_t  mix_idx;

    video_timing u_timing (
        .clk        ( clk           ),
        .rst        ( rst           ),
        .pxl_cen    ( pxl_cen       ),
        .hdump      ( hdump         ),
        .vdump      ( vdump         ),
        .HB         ( HB            ),
        .VB         ( VB            ),
        .HS         ( HS            ),
        .VS         ( VS            )
    );

    // Registers decode the low word address bits
    ppu_mmr u_mmr (
        .clk        ( clk           ),
        .rst        ( rst           ),
        .pxl_cen    ( pxl_cen       ),
        .ppu_cs     ( ppu_cs        ),
        .cpu_we     ( cpu_we        ),
        .addr       ( addr[4:0]     ),
        .dsn        ( dsn           ),
        .cpu_dout   ( cpu_dout      ),
        .vdump      ( vdump         ),
        .mmr_dout   ( mmr_dout      ),
        .layer_ctrl ( layer_ctrl    ),
        .backdrop   ( backdrop      ),
        .raster     ( raster        )
    );

    layer_mixer u_mixer (
        .clk        ( clk           ),
        .rst        ( rst           ),
        .pxl_cen    ( pxl_cen       ),
        .layer_ctrl ( layer_ctrl    ),
        .backdrop   ( backdrop      ),
        .obj_pxl    ( obj_pxl       ),
        .scr1_pxl   ( scr1_pxl      ),
        .scr2_pxl   ( scr2_pxl      ),
        .scr3_pxl   ( scr3_pxl      ),
        .mix_idx    ( mix_idx       )
    );

    palette u_pal (
        .clk        ( clk           ),
        .rst        ( rst           ),
        .pxl_cen    ( pxl_cen       ),
        .pal_cs     ( pal_cs        ),
        .addr       ( addr          ),
        .dsn        ( dsn           ),
        .cpu_dout   ( cpu_dout      ),
        .mix_idx    ( mix_idx       ),
        .HB         ( HB            ),
        .VB         ( VB            ),
        .red        ( red           ),
        .green      ( green         ),
        .blue       ( blue          ),
        .LHBL_dly   ( LHBL_dly      ),
        .LVBL_dly   ( LVBL_dly      )
    );

endmodule

// ==== hdl/palette.sv ====
`timescale 1ns/1ps

module palette
    import video_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       pxl_cen,
    input  logic       pal_cs,
    input  pal_idx_t   addr,
    input  logic [1:0] dsn,
    input  pal_entry_t cpu_dout,
    input  pal_idx_t   mix_idx,
    input  logic       HB,
    input  logic       VB,
    output channel_t   red,
    output channel_t   green,
    output channel_t   blue,
    output logic       LHBL_dly,
    output logic       LVBL_dly
);

    pal_entry_t             pal_ram [PAL_ENTRIES];
    pal_entry_t             rd_entry;
    logic [PIPE_DEPTH-1:0]  hb_sr;
    logic [PIPE_DEPTH-1:0]  vb_sr;
    logic                   blank_next;

    // CPU port, per byte lane
    always_ff @(posedge clk) begin
        if (pal_cs) begin
            if (!dsn[1]) begin
                pal_ram[addr][15:8] <= cpu_dout[15:8];
            end
            if (!dsn[0]) begin
                pal_ram[addr][7:0] <= cpu_dout[7:0];
            end
        end
    end

    // Video port, first step
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            rd_entry <= pal_ram[mix_idx];
        end
    end

    // Blanking travels through the same number of steps as the pixel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hb_sr <= '1;
            vb_sr <= '1;
        end else if (pxl_cen) begin
            hb_sr <= {hb_sr[PIPE_DEPTH-2:0], HB};
            vb_sr <= {vb_sr[PIPE_DEPTH-2:0], VB};
        end
    end

    assign LHBL_dly = ~hb_sr[PIPE_DEPTH-1];
    assign LVBL_dly = ~vb_sr[PIPE_DEPTH-1];

    // Blanking that enters the last stage together with the colour
    assign blank_next = hb_sr[PIPE_DEPTH-2] | vb_sr[PIPE_DEPTH-2];

    // Output register, nibbles doubled to 8 bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (pxl_cen) begin
            red   <= blank_next ? '0 : {rd_entry[11:8], rd_entry[11:8]};
            green <= blank_next ? '0 : {rd_entry[7:4], rd_entry[7:4]};
            blue  <= blank_next ? '0 : {rd_entry[3:0], rd_entry[3:0]};
        end
    end

endmodule

// ==== hdl/layer_mixer.sv ====
`timescale 1ns/1ps

module layer_mixer
    import video_pkg::*;
    import ppu_regs_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       pxl_cen,
    input  cpu_word_t  layer_ctrl,
    input  pal_idx_t   backdrop,
    input  layer_pxl_t obj_pxl,
    input  layer_pxl_t scr1_pxl,
    input  layer_pxl_t scr2_pxl,
    input  layer_pxl_t scr3_pxl,
    output pal_idx_t   mix_idx
);

    layer_pxl_t by_id   [NUM_LAYERS];
    layer_id_t  fld_id  [NUM_LAYERS];
    layer_pxl_t fld_pxl [NUM_LAYERS];
    logic       fld_vis [NUM_LAYERS];
    pal_idx_t   mix_next;

    // Layer pixels indexed by layer identity
    always_comb begin
        by_id[LAYER_OBJ]  = obj_pxl;
        by_id[LAYER_SCR1] = scr1_pxl;
        by_id[LAYER_SCR2] = scr2_pxl;
        by_id[LAYER_SCR3] = scr3_pxl;
    end

    // Resolve each priority field to a pixel and a visibility flag
    always_comb begin
        for (int f = 0; f < NUM_LAYERS; f++) begin
            fld_id[f]  = layer_ctrl[2*f +: 2];
            fld_pxl[f] = by_id[fld_id[f]];
            fld_vis[f] = layer_ctrl[LAYER_EN_LSB + fld_id[f]] &&
                         fld_pxl[f][3:0] != TRANSPARENT_COLOR;
        end
    end

    // Bottom to top, so a higher field overrides what is below it
    always_comb begin
        mix_next = backdrop;
        for (int f = 0; f < NUM_LAYERS; f++) begin
            if (fld_vis[f]) begin
                mix_next = {fld_id[f], fld_pxl[f]};
            end
        end
    end

    // One pixel step
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mix_idx <= '0;
        end else if (pxl_cen) begin
            mix_idx <= mix_next;
        end
    end

endmodule

// ==== hdl/ppu_mmr.sv ====
`timescale 1ns/1ps

module ppu_mmr
    import video_pkg::*;
    import ppu_regs_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       pxl_cen,
    input  logic       ppu_cs,
    input  logic       cpu_we,
    input  reg_addr_t  addr,
    input  logic [1:0] dsn,
    input  cpu_word_t  cpu_dout,
    input  vcount_t    vdump,
    output cpu_word_t  mmr_dout,
    output cpu_word_t  layer_ctrl,
    output pal_idx_t   backdrop,
    output logic       raster
);

    cpu_word_t raster_reg;
    cpu_word_t backdrop_reg;
    logic      wr_en;
    logic      raster_hit;

    assign wr_en = ppu_cs & cpu_we;

    // CPU writes, any clk cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            layer_ctrl   <= '0;
            raster_reg   <= '0;
            backdrop_reg <= '0;
        end else if (wr_en) begin
            case (addr)
                REG_LAYER_CTRL: begin
                    layer_ctrl <= lane_merge(layer_ctrl, cpu_dout, dsn);
                end
                REG_RASTER: begin
                    raster_reg <= lane_merge(raster_reg, cpu_dout, dsn);
                end
                REG_BACKDROP: begin
                    backdrop_reg <= lane_merge(backdrop_reg, cpu_dout, dsn);
                end
                default: begin
                end
            endcase
        end
    end

    // Read back the full word as written
    always_comb begin
        case (addr)
            REG_LAYER_CTRL: mmr_dout = layer_ctrl;
            REG_RASTER:     mmr_dout = raster_reg;
            REG_BACKDROP:   mmr_dout = backdrop_reg;
            default:        mmr_dout = UNMAPPED_READ;
        endcase
    end

    // Only the index bits reach the mixer
    assign backdrop = pal_idx_t'(backdrop_reg);

    // Line match against the low bits of the raster register
    assign raster_hit = raster_reg[RASTER_EN_BIT] && vdump == vcount_t'(raster_reg);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            raster <= 1'b0;
        end else if (pxl_cen) begin
            raster <= raster_hit;
        end
    end

endmodule

// ==== hdl/video_timing.sv ====
`timescale 1ns/1ps

module video_timing
    import video_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    pxl_cen,
    output hcount_t hdump,
    output vcount_t vdump,
    output logic    HB,
    output logic    VB,
    output logic    HS,
    output logic    VS
);

    hcount_t h_next;
    vcount_t v_next;
    logic    line_end;
    logic    frame_end;
    logic    hb_next;
    logic    vb_next;
    logic    hs_next;
    logic    vs_next;

    // Next counter values
    always_comb begin
        line_end  = hdump == hcount_t'(H_TOTAL - 1);
        frame_end = vdump == vcount_t'(V_TOTAL - 1);
        h_next    = line_end ? '0 : hdump + 1'b1;
        if (line_end) begin
            v_next = frame_end ? '0 : vdump + 1'b1;
        end else begin
            v_next = vdump;
        end
    end

    // Decode from the next count so the flags land together with it
    always_comb begin
        hb_next = h_next < hcount_t'(H_VIS_START) || h_next >= hcount_t'(H_VIS_END);
        vb_next = v_next < vcount_t'(V_VIS_START) || v_next >= vcount_t'(V_VIS_END);
        hs_next = h_next >= hcount_t'(H_SYNC_START) && h_next < hcount_t'(H_SYNC_END);
        vs_next = v_next >= vcount_t'(V_SYNC_START) && v_next < vcount_t'(V_SYNC_END);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump <= '0;
            vdump <= '0;
            HB    <= 1'b1;
            VB    <= 1'b1;
            HS    <= 1'b0;
            VS    <= 1'b0;
        end else if (pxl_cen) begin
            hdump <= h_next;
            vdump <= v_next;
            HB    <= hb_next;
            VB    <= vb_next;
            HS    <= hs_next;
            VS    <= vs_next;
        end
    end

endmodule

// ==== hdl/ppu_regs_pkg.sv ====
package ppu_regs_pkg;

    // CPU bus word and register word address
    typedef logic [15:0] cpu_word_t;
    typedef logic [4:0]  reg_addr_t;

    // Register map
    localparam reg_addr_t REG_RASTER     = 5'd14;
    localparam reg_addr_t REG_LAYER_CTRL = 5'd19;
    localparam reg_addr_t REG_BACKDROP   = 5'd20;

    // Field positions
    localparam int LAYER_EN_LSB  = 8;
    localparam int RASTER_EN_BIT = 15;

    localparam cpu_word_t UNMAPPED_READ = 16'hffff;

    // Byte lane merge, dsn[1] selects the upper byte, active low
    function automatic cpu_word_t lane_merge(
        input cpu_word_t  old_word,
        input cpu_word_t  new_word,
        input logic [1:0] dsn
    );
        cpu_word_t merged;
        merged = old_word;
        if (!dsn[1]) begin
            merged[15:8] = new_word[15:8];
        end
        if (!dsn[0]) begin
            merged[7:0] = new_word[7:0];
        end
        return merged;
    endfunction

endpackage

// ==== hdl/video_pkg.sv ====
package video_pkg;

    // Raster positions
    typedef logic [8:0] hcount_t;
    typedef logic [8:0] vcount_t;

    localparam int H_TOTAL      = 512;
    localparam int H_VIS_START  = 64;
    localparam int H_VIS_END    = 448;
    localparam int H_SYNC_START = 464;
    localparam int H_SYNC_END   = 496;

    localparam int V_TOTAL      = 262;
    localparam int V_VIS_START  = 16;
    localparam int V_VIS_END    = 240;
    localparam int V_SYNC_START = 248;
    localparam int V_SYNC_END   = 251;

    // Layer pixel is palette nibble over colour nibble
    typedef logic [7:0] layer_pxl_t;

    localparam logic [3:0] TRANSPARENT_COLOR = 4'd15;

    // Layer identities, also the top bits of a palette index
    typedef logic [1:0] layer_id_t;

    localparam layer_id_t LAYER_OBJ  = 2'd0;
    localparam layer_id_t LAYER_SCR1 = 2'd1;
    localparam layer_id_t LAYER_SCR2 = 2'd2;
    localparam layer_id_t LAYER_SCR3 = 2'd3;

    localparam int NUM_LAYERS = 4;

    // Palette index is layer id followed by the layer pixel
    typedef logic [9:0] pal_idx_t;

    localparam int PAL_ENTRIES = 1024;

    // Palette word, RGB444 in bits 11:0
    typedef logic [15:0] pal_entry_t;

    typedef logic [7:0] channel_t;

    // Pixel-enable steps from layer inputs to RGB
    localparam int PIPE_DEPTH = 3;

endpackage
